//--- biu.f
logic/biu_pkg.sv
logic/bus_cycle_fsm.sv
logic/prefetch_queue.sv
logic/intr_ack_fsm.sv
logic/hold_arbiter.sv
logic/biu_top.sv
testbench/biu_assert.sv
testbench/biu_tb.sv

//--- Makefile
TOP := biu_tb

all: run

build:
	verilator --binary --timing --assert -f biu.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q -F '*** FAILED ***' sim.log; then exit 1; fi
	@grep -q -F '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert -f biu.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- testbench/biu_tb.sv
// directed testbench for biu_top; the bus model has no wait states and reads back low address byte xor 5A
module biu_tb;
    import biu_pkg::*;

    localparam int TIMEOUT = 100;

    logic              clk = 1'b0;
    logic              rst;
    logic              fetch_i;
    logic              write_i;
    logic              wr_byte_i;
    logic              intr_i;
    logic              hold_i;
    logic [ADDR_W-1:0] fetch_addr_i;
    logic [ADDR_W-1:0] wr_addr_i;
    logic [ADDR_W-1:0] rd_addr_i;
    logic [ADDR_W-1:0] addr_o;
    logic [DATA_W-1:0] wr_data_i;
    logic [DATA_W-1:0] rd_word_o;
    logic [BYTE_W-1:0] ad_i = '0;
    logic [BYTE_W-1:0] ad_o;
    logic [BYTE_W-1:0] vector_o;
    logic              done_o;
    logic              busy_o;
    logic              rd_hit_o;
    logic              vector_valid_o;
    logic              ad_oe_o;
    logic              ale_o;
    logic              rd_n_o;
    logic              wr_n_o;
    logic              den_n_o;
    logic              dtr_o;
    logic              inta_n_o;
    logic              hlda_o;

    // bus model state
    logic [BYTE_W-1:0] vec;             // byte returned during inta
    logic [ADDR_W-1:0] lat_addr;
    logic              wr_n_q = 1'b1;
    logic [ADDR_W-1:0] ale_log[$];
    logic [ADDR_W-1:0] wr_log_addr[$];
    logic [BYTE_W-1:0] wr_log_data[$];
    int errors = 0;
    int checks = 0;
    int tests  = 0;

    biu_top biu_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic [BYTE_W-1:0] mem_byte(input logic [ADDR_W-1:0] a);
        return a[BYTE_W-1:0] ^ 8'h5A;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic fail_timeout(input string what);
        errors++;
        $display("timeout: no %s seen at t=%0t", what, $time);
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        $display("test %s finished with %0d errors", name, errors - e0);
    endtask

    // address latch on ale, memory answers on rd_n and the vector on inta_n
    always @(posedge clk) begin
        wr_n_q <= wr_n_o;
        if (ale_o) begin
            lat_addr <= {addr_o[ADDR_W-1:BYTE_W], ad_o};  // low byte from the ad lines
            ale_log.push_back(addr_o);
            check("ad_oe_o", 32'(ad_oe_o), 32'd1);
        end
        if (!rd_n_o) begin
            ad_i <= mem_byte(lat_addr);
            check("den_n_o", 32'(den_n_o), 32'd0);
            check("dtr_o", 32'(dtr_o), 32'd0);
            check("ad_oe_o", 32'(ad_oe_o), 32'd0);
        end else if (!inta_n_o) begin
            ad_i <= vec;
        end
        if (!wr_n_o && wr_n_q) begin  // first write clock of a byte
            wr_log_addr.push_back(lat_addr);
            wr_log_data.push_back(ad_o);
            check("dtr_o", 32'(dtr_o), 32'd1);
            check("den_n_o", 32'(den_n_o), 32'd0);
            check("ad_oe_o", 32'(ad_oe_o), 32'd1);
        end
    end

    task automatic strobe_fetch(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        fetch_i      <= 1'b1;
        fetch_addr_i <= a;
        @(posedge clk);
        fetch_i <= 1'b0;
    endtask

    task automatic strobe_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                                input logic one);
        @(posedge clk);
        write_i   <= 1'b1;
        wr_addr_i <= a;
        wr_data_i <= d;
        wr_byte_i <= one;
        @(posedge clk);
        write_i <= 1'b0;
    endtask

    // cycle of done_o counted from the strobe cycle
    task automatic wait_done(output int cyc, output logic saw_hlda);
        cyc      = 1;
        saw_hlda = 1'b0;
        @(negedge clk);
        while (!done_o && cyc < TIMEOUT) begin
            saw_hlda = saw_hlda | hlda_o;
            cyc++;
            @(negedge clk);
        end
        if (!done_o)
            fail_timeout("done_o");
    endtask

    task automatic check_window(input logic [ADDR_W-1:0] base);
        logic [ADDR_W-1:0] a;
        for (int k = 0; k < QUEUE_BYTES - 1; k++) begin
            a = base + ADDR_W'(k);
            @(posedge clk);
            rd_addr_i <= a;
            @(negedge clk);
            check("rd_hit_o", 32'(rd_hit_o), 32'd1);
            check("rd_word_o", 32'(rd_word_o),
                  32'({mem_byte(a + ADDR_W'(1)), mem_byte(a)}));
        end
        @(posedge clk);
        rd_addr_i <= base + ADDR_W'(QUEUE_BYTES - 1);  // upper byte outside window
        @(negedge clk);
        check("rd_hit_o", 32'(rd_hit_o), 32'd0);
        check("rd_word_o", 32'(rd_word_o), 32'd0);
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        @(negedge clk);
        check("ale_o", 32'(ale_o), 32'd0);
        check("rd_n_o", 32'(rd_n_o), 32'd1);
        check("wr_n_o", 32'(wr_n_o), 32'd1);
        check("den_n_o", 32'(den_n_o), 32'd1);
        check("inta_n_o", 32'(inta_n_o), 32'd1);
        check("dtr_o", 32'(dtr_o), 32'd1);
        check("ad_oe_o", 32'(ad_oe_o), 32'd0);
        check("done_o", 32'(done_o), 32'd0);
        check("busy_o", 32'(busy_o), 32'd0);
        check("hlda_o", 32'(hlda_o), 32'd0);
        check("vector_valid_o", 32'(vector_valid_o), 32'd0);
        check("rd_hit_o", 32'(rd_hit_o), 32'd1);
        check("rd_word_o", 32'(rd_word_o), 32'd0);
        report("reset", e0);
    endtask

    task automatic fetch_burst();
        int                e0;
        int                cyc;
        logic              hl;
        logic [ADDR_W-1:0] base;
        e0   = errors;
        base = ADDR_W'($urandom);
        ale_log.delete();
        strobe_fetch(base);
        wait_done(cyc, hl);
        check("done_o cycle", 32'(cyc), 32'(3 * QUEUE_BYTES + 1));
        check("ale_o pulses", 32'(ale_log.size()), 32'(QUEUE_BYTES));
        foreach (ale_log[k])
            check("addr_o", 32'(ale_log[k]), 32'(base + ADDR_W'(k)));
        check_window(base);
        report("fetch", e0);
    endtask

    task automatic write_word_and_byte();
        int                e0;
        int                cyc;
        logic              hl;
        logic [ADDR_W-1:0] exp_a[3];
        logic [DATA_W-1:0] wd;
        logic [DATA_W-1:0] bd;
        e0       = errors;
        exp_a[0] = ADDR_W'($urandom);
        exp_a[1] = exp_a[0] + ADDR_W'(1);
        exp_a[2] = ADDR_W'($urandom);
        wd       = DATA_W'($urandom);
        bd       = DATA_W'($urandom);
        wr_log_addr.delete();
        wr_log_data.delete();
        strobe_write(exp_a[0], wd, 1'b0);
        wait_done(cyc, hl);
        check("done_o cycle", 32'(cyc), 32'd7);
        strobe_write(exp_a[2], bd, 1'b1);
        wait_done(cyc, hl);
        check("done_o cycle", 32'(cyc), 32'd4);
        check("write bytes", 32'(wr_log_data.size()), 32'd3);
        if (wr_log_data.size() == 3) begin
            for (int k = 0; k < 3; k++)
                check("write addr", 32'(wr_log_addr[k]), 32'(exp_a[k]));
            check("write data", 32'(wr_log_data[0]), 32'(wd[7:0]));
            check("write data", 32'(wr_log_data[1]), 32'(wd[15:8]));
            check("write data", 32'(wr_log_data[2]), 32'(bd[7:0]));  // high byte dropped
        end
        report("write", e0);
    endtask

    task automatic intr_acknowledge();
        int         e0;
        int         cyc;
        logic [7:0] pat;
        e0  = errors;
        vec = BYTE_W'($urandom);
        pat = '0;
        cyc = 1;
        @(posedge clk);
        intr_i <= 1'b1;
        @(posedge clk);
        intr_i <= 1'b0;
        @(negedge clk);
        while (!vector_valid_o && cyc < TIMEOUT) begin
            pat = {pat[6:0], inta_n_o};
            cyc++;
            @(negedge clk);
        end
        if (!vector_valid_o)
            fail_timeout("vector_valid_o");
        check("inta_n_o pattern", 32'(pat), 32'b00100);  // low low high low low
        check("vector_valid_o cycle", 32'(cyc), 32'd6);
        check("inta_n_o", 32'(inta_n_o), 32'd1);
        check("vector_o", 32'(vector_o), 32'(vec));
        report("intr", e0);
    endtask

    task automatic hold_in_fetch();
        int                e0;
        int                cyc;
        logic              hl;
        logic [ADDR_W-1:0] base;
        e0 = errors;
        strobe_fetch(ADDR_W'($urandom));
        repeat (6) @(posedge clk);
        hold_i <= 1'b1;  // mid burst
        wait_done(cyc, hl);
        check("hlda_o during fetch", 32'(hl | hlda_o), 32'd0);
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!hlda_o && cyc < TIMEOUT);
        if (!hlda_o)
            fail_timeout("hlda_o rise");
        check("hlda_o rise delay", 32'(cyc), 32'd1);
        check("busy_o", 32'(busy_o), 32'd1);
        ale_log.delete();
        strobe_fetch(ADDR_W'($urandom));
        repeat (8) @(negedge clk);
        check("ale_o pulses in hold", 32'(ale_log.size()), 32'd0);
        @(posedge clk);
        hold_i <= 1'b0;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (hlda_o && cyc < TIMEOUT);
        if (hlda_o)
            fail_timeout("hlda_o fall");
        check("hlda_o fall delay", 32'(cyc), 32'd2);  // counted from the drop of hold_i
        base = ADDR_W'($urandom);
        strobe_fetch(base);
        wait_done(cyc, hl);
        check("done_o cycle", 32'(cyc), 32'(3 * QUEUE_BYTES + 1));
        check_window(base);
        report("hold", e0);
    endtask

    initial begin
        void'($urandom(32'h43fdca63));
        rst          = 1'b0;
        fetch_i      = 1'b0;
        write_i      = 1'b0;
        wr_byte_i    = 1'b0;
        intr_i       = 1'b0;
        hold_i       = 1'b0;
        fetch_addr_i = '0;
        wr_addr_i    = '0;
        wr_data_i    = '0;
        rd_addr_i    = RESET_BASE;
        vec          = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        reset_values();
        fetch_burst();
        write_word_and_byte();
        intr_acknowledge();
        hold_in_fetch();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- testbench/biu_assert.sv
// bus strobe rules of the sequencer, bound into bus_cycle_fsm; checked only out of reset
module biu_assert (
    input logic                clk,
    input logic                rst,
    input biu_pkg::bus_state_t state_i,
    input logic                ale_i,
    input logic                rd_n_i,
    input logic                wr_n_i,
    input logic                den_n_i
);
    import biu_pkg::*;

    // one strobe at a time, held for T2 and T3 and then released
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst)
                                      $fell(rd_n_i && wr_n_i) |->
                                      (rd_n_i != wr_n_i) ##1 (rd_n_i != wr_n_i) ##1
                                      (rd_n_i && wr_n_i))
        else $error("rd_n and wr_n not a single two-clock strobe");

    // one clock of ale, data phase right after
    ale_only_t1: assert property (@(posedge clk) disable iff (!rst)
                                  ale_i |-> (state_i == T1) ##1 (!ale_i && !den_n_i))
        else $error("ale high outside T1 or not followed by the data phase");

    // transceiver off between cycles and in the T1 after idle
    den_off_idle: assert property (@(posedge clk) disable iff (!rst)
                                   (state_i == T_IDLE) |-> den_n_i ##1 den_n_i)
        else $error("den_n low while idle");

endmodule

bind bus_cycle_fsm biu_assert biu_assert_i (
    .clk     (clk),
    .rst     (rst),
    .state_i (state),
    .ale_i   (ale_o),
    .rd_n_i  (rd_n_o),
    .wr_n_i  (wr_n_o),
    .den_n_i (den_n_o)
);

//--- logic/biu_top.sv
// 8088-style bus interface unit without the execution core; no ready input, no wait states, strobes ignored while busy_o is high
module biu_top (
    input  logic                       clk,
    input  logic                       rst,

    // core side
    input  logic                       fetch_i,
    input  logic [biu_pkg::ADDR_W-1:0] fetch_addr_i,
    input  logic                       write_i,
    input  logic [biu_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [biu_pkg::DATA_W-1:0] wr_data_i,
    input  logic                       wr_byte_i,
    output logic                       done_o,
    output logic                       busy_o,
    input  logic [biu_pkg::ADDR_W-1:0] rd_addr_i,
    output logic [biu_pkg::DATA_W-1:0] rd_word_o,
    output logic                       rd_hit_o,
    output logic [biu_pkg::BYTE_W-1:0] vector_o,
    output logic                       vector_valid_o,

    // bus side
    output logic [biu_pkg::ADDR_W-1:0] addr_o,
    input  logic [biu_pkg::BYTE_W-1:0] ad_i,
    output logic [biu_pkg::BYTE_W-1:0] ad_o,
    output logic                       ad_oe_o,
    output logic                       ale_o,
    output logic                       rd_n_o,
    output logic                       wr_n_o,
    output logic                       den_n_o,
    output logic                       dtr_o,
    input  logic                       intr_i,
    output logic                       inta_n_o,
    input  logic                       hold_i,
    output logic                       hlda_o
);
    import biu_pkg::*;

    logic             q_start;
    logic             q_load;
    logic [CNT_W-1:0] q_index;
    logic             bus_free;
    logic             intr_busy;
    logic             hlda;

    assign hlda_o = hlda;

    bus_cycle_fsm bus_cycle_fsm_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_i      (fetch_i),
        .fetch_addr_i (fetch_addr_i),
        .write_i      (write_i),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .wr_byte_i    (wr_byte_i),
        .intr_busy_i  (intr_busy),
        .hlda_i       (hlda),
        .addr_o       (addr_o),
        .ad_o         (ad_o),
        .ad_oe_o      (ad_oe_o),
        .ale_o        (ale_o),
        .rd_n_o       (rd_n_o),
        .wr_n_o       (wr_n_o),
        .den_n_o      (den_n_o),
        .dtr_o        (dtr_o),
        .done_o       (done_o),
        .busy_o       (busy_o),
        .bus_free_o   (bus_free),
        .q_start_o    (q_start),
        .q_load_o     (q_load),
        .q_index_o    (q_index)
    );

    prefetch_queue prefetch_queue_i (
        .clk          (clk),
        .rst          (rst),
        .q_start_i    (q_start),
        .fetch_addr_i (fetch_addr_i),
        .q_load_i     (q_load),
        .q_index_i    (q_index),
        .ad_i         (ad_i),
        .rd_addr_i    (rd_addr_i),
        .rd_word_o    (rd_word_o),
        .rd_hit_o     (rd_hit_o)
    );

    intr_ack_fsm intr_ack_fsm_i (
        .clk            (clk),
        .rst            (rst),
        .intr_i         (intr_i),
        .bus_free_i     (bus_free),
        .ad_i           (ad_i),
        .inta_n_o       (inta_n_o),
        .intr_busy_o    (intr_busy),
        .vector_o       (vector_o),
        .vector_valid_o (vector_valid_o)
    );

    hold_arbiter hold_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .hold_i      (hold_i),
        .bus_free_i  (bus_free),
        .intr_busy_i (intr_busy),
        .hlda_o      (hlda)
    );

endmodule

//--- logic/hold_arbiter.sv
// grants only on a free bus with no interrupt cycle; the bus is given back one clock after hold_i drops
module hold_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic hold_i,
    input  logic bus_free_i,
    input  logic intr_busy_i,
    output logic hlda_o
);

    typedef enum logic {
        H_IDLE,
        H_GRANT
    } hold_state_t;

    hold_state_t state;
    logic        grant;

    // lowest priority of the three bus owners
    assign grant = hold_i && bus_free_i && !intr_busy_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= H_IDLE;
        end else begin
            case (state)
                H_IDLE:  if (grant) state <= H_GRANT;
                H_GRANT: if (!hold_i) state <= H_IDLE;  // external master done
                default: state <= H_IDLE;
            endcase
        end
    end

    assign hlda_o = (state == H_GRANT);

endmodule

//--- logic/intr_ack_fsm.sv
// two inta pulses of two clocks with a one-clock gap; vector taken from ad_i in the last low cycle, intr_i is level sensitive
module intr_ack_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       intr_i,
    input  logic                       bus_free_i,
    input  logic [biu_pkg::BYTE_W-1:0] ad_i,
    output logic                       inta_n_o,
    output logic                       intr_busy_o,
    output logic [biu_pkg::BYTE_W-1:0] vector_o,
    output logic                       vector_valid_o
);

    typedef enum logic [1:0] {
        I_IDLE, I_PULSE1, I_GAP, I_PULSE2
    } ack_state_t;

    ack_state_t state;
    logic       second;  // second clock of a pulse
    logic       start;
    logic       sample;

    assign start  = (state == I_IDLE) && intr_i && bus_free_i;
    assign sample = (state == I_PULSE2) && second;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= I_IDLE;
            second         <= 1'b0;
            vector_valid_o <= 1'b0;
        end else begin
            vector_valid_o <= sample;
            case (state)
                I_IDLE:   if (start) state <= I_PULSE1;
                I_PULSE1: begin
                    second <= !second;
                    if (second) state <= I_GAP;
                end
                I_GAP:    state <= I_PULSE2;
                I_PULSE2: begin
                    second <= !second;
                    if (second) state <= I_IDLE;
                end
                default:  state <= I_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample)
            vector_o <= ad_i;
    end

    assign inta_n_o = !((state == I_PULSE1) || (state == I_PULSE2));

    // start term keeps a hold request off the bus in the same cycle
    assign intr_busy_o = (state != I_IDLE) || start;

endmodule

//--- logic/prefetch_queue.sv
// one fetch burst refills the whole queue; the word port only hits when both bytes lie in the window
module prefetch_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       q_start_i,
    input  logic [biu_pkg::ADDR_W-1:0] fetch_addr_i,
    input  logic                       q_load_i,
    input  logic [biu_pkg::CNT_W-1:0]  q_index_i,
    input  logic [biu_pkg::BYTE_W-1:0] ad_i,
    input  logic [biu_pkg::ADDR_W-1:0] rd_addr_i,
    output logic [biu_pkg::DATA_W-1:0] rd_word_o,
    output logic                       rd_hit_o
);
    import biu_pkg::*;

    logic [BYTE_W-1:0] q_mem [QUEUE_BYTES];
    logic [ADDR_W-1:0] base;    // address of q_mem[0]
    logic [ADDR_W-1:0] offset;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            base <= RESET_BASE;
            for (int i = 0; i < QUEUE_BYTES; i++)
                q_mem[i] <= '0;
        end else if (q_start_i) begin
            base <= fetch_addr_i;
            for (int i = 0; i < QUEUE_BYTES; i++)
                q_mem[i] <= '0;  // stale bytes gone before the burst
        end else if (q_load_i) begin
            for (int i = 0; i < QUEUE_BYTES; i++) begin
                if (q_index_i == CNT_W'(i))
                    q_mem[i] <= ad_i;
            end
        end
    end

    // wraps below base, so that also misses
    assign offset = rd_addr_i - base;

    always_comb begin
        rd_word_o = '0;
        rd_hit_o  = 1'b0;
        for (int i = 0; i < QUEUE_BYTES - 1; i++) begin
            if (offset == ADDR_W'(i)) begin
                rd_word_o = {q_mem[i+1], q_mem[i]};  // little endian word
                rd_hit_o  = 1'b1;
            end
        end
    end

endmodule

//--- logic/bus_cycle_fsm.sv
// three-clock byte cycles, no wait states; fetch bursts are always QUEUE_BYTES long, writes go low byte first
module bus_cycle_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_i,
    input  logic [biu_pkg::ADDR_W-1:0] fetch_addr_i,
    input  logic                       write_i,
    input  logic [biu_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [biu_pkg::DATA_W-1:0] wr_data_i,
    input  logic                       wr_byte_i,
    input  logic                       intr_busy_i,
    input  logic                       hlda_i,
    output logic [biu_pkg::ADDR_W-1:0] addr_o,
    output logic [biu_pkg::BYTE_W-1:0] ad_o,
    output logic                       ad_oe_o,
    output logic                       ale_o,
    output logic                       rd_n_o,
    output logic                       wr_n_o,
    output logic                       den_n_o,
    output logic                       dtr_o,
    output logic                       done_o,
    output logic                       busy_o,
    output logic                       bus_free_o,
    output logic                       q_start_o,
    output logic                       q_load_o,
    output logic [biu_pkg::CNT_W-1:0]  q_index_o
);
    import biu_pkg::*;

    bus_state_t        state;
    logic [CNT_W-1:0]  cnt;       // byte within the current request
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] wr_data;
    logic              is_fetch;  // request kind, low for a write
    logic              one_byte;

    logic idle;
    logic can_start;
    logic start_fetch;
    logic start_write;
    logic last_byte;
    logic data_phase;
    logic rd_phase;
    logic wr_phase;

    assign idle = (state == T_IDLE);

    // a strobe wins over a pending interrupt or hold, since bus_free drops with it
    assign can_start   = idle && !intr_busy_i && !hlda_i;
    assign start_fetch = can_start && fetch_i;
    assign start_write = can_start && write_i && !fetch_i;  // fetch first if both

    always_comb begin
        if (is_fetch)
            last_byte = (cnt == CNT_W'(QUEUE_BYTES - 1));
        else
            last_byte = one_byte || (cnt == CNT_W'(1));
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= T_IDLE;
            cnt      <= '0;
            is_fetch <= 1'b0;
            one_byte <= 1'b0;
            req_addr <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                T_IDLE: begin
                    if (start_fetch || start_write) begin
                        state    <= T1;
                        cnt      <= '0;
                        is_fetch <= start_fetch;
                        one_byte <= wr_byte_i;
                        req_addr <= start_fetch ? fetch_addr_i : wr_addr_i;
                    end
                end
                T1: state <= T2;
                T2: state <= T3;
                T3: begin
                    if (last_byte) begin
                        state  <= T_IDLE;
                        done_o <= 1'b1;  // one cycle after the last T3
                    end else begin
                        state <= T1;
                        cnt   <= cnt + 1'b1;
                    end
                end
                default: state <= T_IDLE;
            endcase
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (start_write)
            wr_data <= wr_data_i;
    end

    assign data_phase = (state == T2) || (state == T3);
    assign rd_phase   = data_phase && is_fetch;
    assign wr_phase   = data_phase && !is_fetch;

    // byte k of a request sits at base plus k
    assign addr_o = req_addr + ADDR_W'(cnt);

    assign ale_o   = (state == T1);
    assign rd_n_o  = !rd_phase;
    assign wr_n_o  = !wr_phase;
    assign den_n_o = !data_phase;
    assign dtr_o   = !rd_phase;  // low only while receiving
    assign ad_oe_o = ale_o || wr_phase;

    // multiplexed bus, address in T1 and data byte after
    always_comb begin
        if (ale_o)
            ad_o = addr_o[BYTE_W-1:0];
        else if (cnt == '0)
            ad_o = wr_data[BYTE_W-1:0];
        else
            ad_o = wr_data[DATA_W-1:BYTE_W];
    end

    assign busy_o     = !idle || intr_busy_i || hlda_i;
    assign bus_free_o = idle && !fetch_i && !write_i && !hlda_i;

    // queue side
    assign q_start_o = start_fetch;
    assign q_load_o  = rd_phase && (state == T3);  // ad_i valid at end of T3
    assign q_index_o = cnt;

endmodule

//--- logic/biu_pkg.sv
// shared widths and bus states of the bus interface unit; queue depth and burst length are one value
package biu_pkg;

    // physical address and data widths
    localparam int ADDR_W = 20;
    localparam int DATA_W = 16;  // core side word
    localparam int BYTE_W = 8;   // multiplexed bus byte

    // one fetch burst fills the whole queue
    localparam int QUEUE_BYTES = 8;

    // byte counter, wide enough for a full burst
    localparam int CNT_W = 4;

    // queue base after reset, the 8088 restart location
    localparam logic [ADDR_W-1:0] RESET_BASE = 20'hFFFF0;

    // byte cycle states of the sequencer
    typedef enum logic [1:0] {
        T_IDLE = 2'b00,
        T1     = 2'b01,  // address out, ale high
        T2     = 2'b10,  // strobes asserted
        T3     = 2'b11   // read byte sampled at the end
    } bus_state_t;

endpackage
